//--- logic/heapPkg.sv
// Sizes, action codes and error codes shared by the heap RTL and testbench
// Update actions actAdd to actNot must stay contiguous, the decoder tests a range
`default_nettype none

package heapPkg;

  // ------------------------------------------------
  // Geometry
  // ------------------------------------------------
  localparam int arrayCount  = 4;                 // Arrays in the heap
  localparam int arrayLength = 8;                 // Elements per array
  localparam int arrayBits   = 2;                 // Array number width
  localparam int indexBits   = 3;                 // Element index width
  localparam int sizeBits    = 4;                 // Holds 0 to arrayLength
  localparam int dataBits    = 16;                // Element width
  localparam int actionBits  = 5;                 // Action code width
  localparam int errorBits   = 3;                 // Error code width

  // ------------------------------------------------
  // Action codes
  // ------------------------------------------------
  localparam logic [actionBits-1:0] actReset      = 5'd1;   // Clear whole heap
  localparam logic [actionBits-1:0] actWrite      = 5'd2;   // Write, may extend size
  localparam logic [actionBits-1:0] actRead       = 5'd3;
  localparam logic [actionBits-1:0] actSize       = 5'd4;
  localparam logic [actionBits-1:0] actPush       = 5'd5;
  localparam logic [actionBits-1:0] actPop        = 5'd6;
  localparam logic [actionBits-1:0] actAlloc      = 5'd7;   // Returns array number
  localparam logic [actionBits-1:0] actFree       = 5'd8;
  localparam logic [actionBits-1:0] actAdd        = 5'd9;   // First update action
  localparam logic [actionBits-1:0] actAddAfter   = 5'd10;  // Returns old value
  localparam logic [actionBits-1:0] actSubtract   = 5'd11;
  localparam logic [actionBits-1:0] actSubAfter   = 5'd12;  // Returns old value
  localparam logic [actionBits-1:0] actShiftLeft  = 5'd13;
  localparam logic [actionBits-1:0] actShiftRight = 5'd14;
  localparam logic [actionBits-1:0] actOr         = 5'd15;
  localparam logic [actionBits-1:0] actXor        = 5'd16;
  localparam logic [actionBits-1:0] actAnd        = 5'd17;
  localparam logic [actionBits-1:0] actNot        = 5'd18;  // Last update action

  // ------------------------------------------------
  // Error codes
  // ------------------------------------------------
  localparam logic [errorBits-1:0] errNone         = 3'd0;
  localparam logic [errorBits-1:0] errNotAllocated = 3'd1;  // Also double free
  localparam logic [errorBits-1:0] errOutOfBounds  = 3'd2;
  localparam logic [errorBits-1:0] errFull         = 3'd3;
  localparam logic [errorBits-1:0] errEmpty        = 3'd4;
  localparam logic [errorBits-1:0] errNoMemory     = 3'd5;

endpackage

`default_nettype wire

//--- logic/heapAllocator.sv
// Hands out array numbers, reusing freed ones last-in first-out
// allocate and releaseArray must only pulse for requests that passed checks
// Never-used arrays are taken in order 0 upward once the free stack is empty
`timescale 1ns/1ps
`default_nettype none

module heapAllocator (
  input  wire                           clock,
  input  wire                           resetN,
  input  wire                           clearAll,      // Forget every allocation
  input  wire                           allocate,      // Take nextArray
  input  wire                           releaseArray,  // Free the requested array
  input  wire [heapPkg::arrayBits-1:0]  array,         // Requested array
  output logic                          arrayLive,     // Requested array allocated
  output logic [heapPkg::arrayBits-1:0] nextArray,     // What an alloc returns
  output logic                          exhausted      // No array left
);

  logic [heapPkg::arrayCount-1:0] live;                     // One bit per array
  logic [heapPkg::arrayBits-1:0]  freeStack [heapPkg::arrayCount];  // Freed numbers
  logic [heapPkg::arrayBits:0]    stackDepth;               // 0 to arrayCount
  logic [heapPkg::arrayBits:0]    highWater;                // Arrays ever handed out
  logic [heapPkg::arrayBits-1:0]  stackTop;                 // Index of newest entry

  // ------------------------------------------------
  // Combinational answers
  // ------------------------------------------------
  assign stackTop  = stackDepth[heapPkg::arrayBits-1:0] - 1'b1;
  assign arrayLive = live[array];

  always_comb begin
    if (stackDepth != '0) begin
      nextArray = freeStack[stackTop];                      // Reuse newest freed
    end else begin
      nextArray = highWater[heapPkg::arrayBits-1:0];        // Fresh array
    end
  end

  assign exhausted = (stackDepth == '0) &&
    (highWater == (heapPkg::arrayBits + 1)'(heapPkg::arrayCount));

  // ------------------------------------------------
  // Allocation state
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      live       <= '0;
      stackDepth <= '0;
      highWater  <= '0;
    end else if (clearAll) begin
      live       <= '0;                                     // Heap wiped
      stackDepth <= '0;
      highWater  <= '0;
    end else if (allocate) begin
      live[nextArray] <= 1'b1;
      if (stackDepth != '0) begin
        stackDepth <= stackDepth - 1'b1;                    // Pop free stack
      end else begin
        highWater <= highWater + 1'b1;
      end
    end else if (releaseArray) begin
      live[array] <= 1'b0;                                  // The freed array itself
      stackDepth  <= stackDepth + 1'b1;
    end
  end

  // Stack entries are only read below stackDepth
  always_ff @(posedge clock) begin
    if (releaseArray && !clearAll) begin
      freeStack[stackDepth[heapPkg::arrayBits-1:0]] <= array;
    end
  end

endmodule

`default_nettype wire

//--- logic/accessControl.sv
// Checks each request, keeps array sizes and registers the response
// One request per cycle, answered on the next edge, no back-pressure
// Unknown action codes do nothing and answer zero with errNone
`timescale 1ns/1ps
`default_nettype none

module accessControl (
  input  wire                            clock,
  input  wire                            resetN,
  input  wire                            request,       // One-cycle strobe
  input  wire  [heapPkg::actionBits-1:0] action,
  input  wire  [heapPkg::arrayBits-1:0]  array,
  input  wire  [heapPkg::indexBits-1:0]  index,
  input  wire  [heapPkg::dataBits-1:0]   operand,
  input  wire                            arrayLive,     // From allocator
  input  wire  [heapPkg::arrayBits-1:0]  nextArray,
  input  wire                            exhausted,
  input  wire  [heapPkg::dataBits-1:0]   oldValue,      // From element store
  input  wire  [heapPkg::dataBits-1:0]   newValue,
  output logic                           clearAll,
  output logic                           allocate,
  output logic                           releaseArray,
  output logic                           commit,        // Write addressed element
  output logic [heapPkg::indexBits-1:0]  slot,
  output logic [heapPkg::arrayBits-1:0]  writeArray,
  output logic                           done,          // Response strobe
  output logic [heapPkg::dataBits-1:0]   result,
  output logic [heapPkg::errorBits-1:0]  error
);

  logic [heapPkg::sizeBits-1:0]  sizeTable [heapPkg::arrayCount];  // Size per array
  logic [heapPkg::sizeBits-1:0]  currentSize;               // Size of requested array
  logic [heapPkg::errorBits-1:0] checkError;
  logic [heapPkg::dataBits-1:0]  resultNext;
  logic                          updateAction;              // Add through Not
  logic                          inBounds;                  // index below size
  logic                          passed;                    // Request without error

  assign currentSize  = sizeTable[array];
  assign inBounds     = {1'b0, index} < currentSize;
  assign updateAction = (action >= heapPkg::actAdd) && (action <= heapPkg::actNot);
  assign passed       = request && (checkError == heapPkg::errNone);

  // ------------------------------------------------
  // Request checks
  // ------------------------------------------------
  always_comb begin
    checkError = heapPkg::errNone;
    case (action)
      heapPkg::actAlloc: begin
        if (exhausted) checkError = heapPkg::errNoMemory;
      end
      heapPkg::actWrite, heapPkg::actSize, heapPkg::actFree: begin
        if (!arrayLive) checkError = heapPkg::errNotAllocated;  // Covers double free
      end
      heapPkg::actPush: begin
        if (!arrayLive) checkError = heapPkg::errNotAllocated;
        else if (currentSize == (heapPkg::sizeBits)'(heapPkg::arrayLength))
          checkError = heapPkg::errFull;
      end
      heapPkg::actPop: begin
        if (!arrayLive) checkError = heapPkg::errNotAllocated;
        else if (currentSize == '0) checkError = heapPkg::errEmpty;
      end
      default: begin
        if (action == heapPkg::actRead || updateAction) begin   // Bounded access
          if (!arrayLive) checkError = heapPkg::errNotAllocated;
          else if (!inBounds) checkError = heapPkg::errOutOfBounds;
        end
      end
    endcase
  end

  // Strobes to allocator and element store
  assign clearAll     = request && (action == heapPkg::actReset);
  assign allocate     = passed && (action == heapPkg::actAlloc);
  assign releaseArray = passed && (action == heapPkg::actFree);
  assign commit       = passed && (action == heapPkg::actWrite ||
                                   action == heapPkg::actPush || updateAction);
  assign writeArray   = array;

  always_comb begin
    case (action)
      heapPkg::actPush: slot = currentSize[heapPkg::indexBits-1:0];         // Next free
      heapPkg::actPop:  slot = currentSize[heapPkg::indexBits-1:0] - 1'b1;  // Top
      default:          slot = index;
    endcase
  end

  // ------------------------------------------------
  // Result selection
  // ------------------------------------------------
  always_comb begin
    resultNext = '0;                                        // Errors answer zero
    if (checkError == heapPkg::errNone) begin
      case (action)
        heapPkg::actWrite: resultNext = operand;
        heapPkg::actRead, heapPkg::actPop,
        heapPkg::actAddAfter, heapPkg::actSubAfter: resultNext = oldValue;
        heapPkg::actSize:
          resultNext = {{(heapPkg::dataBits - heapPkg::sizeBits){1'b0}}, currentSize};
        heapPkg::actAlloc:
          resultNext = {{(heapPkg::dataBits - heapPkg::arrayBits){1'b0}}, nextArray};
        default: begin
          if (updateAction) resultNext = newValue;          // Reset, Free, Push stay zero
        end
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      done   <= 1'b0;
      result <= '0;
      error  <= heapPkg::errNone;
    end else begin
      done <= request;                                      // Fixed one-cycle latency
      if (request) begin
        result <= resultNext;
        error  <= checkError;
      end
    end
  end

  // ------------------------------------------------
  // Size table
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < heapPkg::arrayCount; i++) sizeTable[i] <= '0;
    end else if (clearAll) begin
      for (int i = 0; i < heapPkg::arrayCount; i++) sizeTable[i] <= '0;
    end else if (passed) begin
      case (action)
        heapPkg::actAlloc: sizeTable[nextArray] <= '0;      // Fresh array starts empty
        heapPkg::actWrite: begin
          if (!inBounds) sizeTable[array] <= {1'b0, index} + 1'b1;  // Extend to index
        end
        heapPkg::actPush:  sizeTable[array] <= currentSize + 1'b1;
        heapPkg::actPop:   sizeTable[array] <= currentSize - 1'b1;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/elementStore.sv
// Element memory with one asynchronous read port and one write port
// Read and write share the address, so an update is read-modify-write in one cycle
// Contents are undefined after reset
`timescale 1ns/1ps
`default_nettype none

module elementStore (
  input  wire                            clock,
  input  wire                            commit,      // Write newValue this edge
  input  wire  [heapPkg::actionBits-1:0] action,
  input  wire  [heapPkg::arrayBits-1:0]  writeArray,
  input  wire  [heapPkg::indexBits-1:0]  slot,
  input  wire  [heapPkg::dataBits-1:0]   operand,
  output logic [heapPkg::dataBits-1:0]   oldValue,    // Element before update
  output logic [heapPkg::dataBits-1:0]   newValue     // Element after update
);

  // Fixed blocks, one row per array
  logic [heapPkg::dataBits-1:0] memory [heapPkg::arrayCount][heapPkg::arrayLength];

  assign oldValue = memory[writeArray][slot];              // Async read

  // ------------------------------------------------
  // Update unit
  // ------------------------------------------------
  always_comb begin
    case (action)
      heapPkg::actAdd,
      heapPkg::actAddAfter:   newValue = oldValue + operand;   // Wraps at 16 bits
      heapPkg::actSubtract,
      heapPkg::actSubAfter:   newValue = oldValue - operand;
      heapPkg::actShiftLeft:  newValue = oldValue << operand;  // Large shifts give zero
      heapPkg::actShiftRight: newValue = oldValue >> operand;  // Logical shift
      heapPkg::actOr:         newValue = oldValue | operand;
      heapPkg::actXor:        newValue = oldValue ^ operand;
      heapPkg::actAnd:        newValue = oldValue & operand;
      heapPkg::actNot:        newValue = ~oldValue;             // Operand ignored
      heapPkg::actWrite,
      heapPkg::actPush:       newValue = operand;              // Plain store
      default:                newValue = oldValue;             // Read, Pop and the rest
    endcase
  end

  // ------------------------------------------------
  // Write port
  // ------------------------------------------------
  always_ff @(posedge clock) begin
    if (commit) begin
      memory[writeArray][slot] <= newValue;
    end
  end

endmodule

`default_nettype wire

//--- logic/arrayHeap.sv
// Heap of four arrays of eight 16-bit elements
// Pulse request with the fields, done follows exactly one cycle later
// A request is accepted every cycle, later requests see earlier effects
`timescale 1ns/1ps
`default_nettype none

module arrayHeap (
  input  wire                            clock,
  input  wire                            resetN,
  input  wire                            request,    // One-cycle strobe
  input  wire  [heapPkg::actionBits-1:0] action,
  input  wire  [heapPkg::arrayBits-1:0]  array,
  input  wire  [heapPkg::indexBits-1:0]  index,
  input  wire  [heapPkg::dataBits-1:0]   operand,
  output logic                           done,       // High one cycle per request
  output logic [heapPkg::dataBits-1:0]   result,
  output logic [heapPkg::errorBits-1:0]  error
);

  // ------------------------------------------------
  // Internal connections
  // ------------------------------------------------
  logic                          clearAll;
  logic                          allocate;
  logic                          releaseArray;
  logic                          arrayLive;
  logic [heapPkg::arrayBits-1:0] nextArray;
  logic                          exhausted;
  logic                          commit;
  logic [heapPkg::indexBits-1:0] slot;
  logic [heapPkg::arrayBits-1:0] writeArray;
  logic [heapPkg::dataBits-1:0]  oldValue;
  logic [heapPkg::dataBits-1:0]  newValue;

  heapAllocator allocator (                          // Array numbers and liveness
    .clock        (clock),
    .resetN       (resetN),
    .clearAll     (clearAll),
    .allocate     (allocate),
    .releaseArray (releaseArray),
    .array        (array),
    .arrayLive    (arrayLive),
    .nextArray    (nextArray),
    .exhausted    (exhausted)
  );

  accessControl control (                            // Checks, sizes, response
    .clock        (clock),
    .resetN       (resetN),
    .request      (request),
    .action       (action),
    .array        (array),
    .index        (index),
    .operand      (operand),
    .arrayLive    (arrayLive),
    .nextArray    (nextArray),
    .exhausted    (exhausted),
    .oldValue     (oldValue),
    .newValue     (newValue),
    .clearAll     (clearAll),
    .allocate     (allocate),
    .releaseArray (releaseArray),
    .commit       (commit),
    .slot         (slot),
    .writeArray   (writeArray),
    .done         (done),
    .result       (result),
    .error        (error)
  );

  elementStore store (                               // Element memory
    .clock        (clock),
    .commit       (commit),
    .action       (action),
    .writeArray   (writeArray),
    .slot         (slot),
    .operand      (operand),
    .oldValue     (oldValue),
    .newValue     (newValue)
  );

endmodule

`default_nettype wire

//--- dv/arrayHeapTb.sv
// Reads requests from dv/heapInput.txt, so the run starts in the project root
// Requests go back to back, each checked one cycle later, stops at the first error
`timescale 1ns/1ps
`default_nettype none

module arrayHeapTb;

  logic                           clock;
  logic                           resetN;
  logic                           request;
  logic [heapPkg::actionBits-1:0] action;
  logic [heapPkg::arrayBits-1:0]  array;
  logic [heapPkg::indexBits-1:0]  index;
  logic [heapPkg::dataBits-1:0]   operand;
  wire                            done;
  wire  [heapPkg::dataBits-1:0]   result;
  wire  [heapPkg::errorBits-1:0]  error;

  logic [heapPkg::actionBits-1:0] actionQ [$];      // One entry per file line
  logic [heapPkg::arrayBits-1:0]  arrayQ [$];
  logic [heapPkg::indexBits-1:0]  indexQ [$];
  logic [heapPkg::dataBits-1:0]   operandQ [$];
  logic [heapPkg::dataBits-1:0]   resultQ [$];      // Expected answers
  logic [heapPkg::errorBits-1:0]  errorQ [$];
  int                             cycleCount;
  int                             cycleLimit;       // Zero until requests are loaded

  arrayHeap DUT (
    .clock   (clock),
    .resetN  (resetN),
    .request (request),
    .action  (action),
    .array   (array),
    .index   (index),
    .operand (operand),
    .done    (done),
    .result  (result),
    .error   (error)
  );

  always #5 clock = ~clock;                         // 10 ns period

  // --------------------------------------------------
  // Failure handling and compare tasks
  // --------------------------------------------------
  task automatic failRun(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkResult(input int n, input logic [heapPkg::dataBits-1:0] got, exp);
    if (got !== exp)
      failRun($sformatf("MISMATCH result request %0d got 0x%h expected 0x%h", n, got, exp));
  endtask

  task automatic checkError(input int n, input logic [heapPkg::errorBits-1:0] got, exp);
    if (got !== exp)
      failRun($sformatf("MISMATCH error request %0d got 0x%h expected 0x%h", n, got, exp));
  endtask

  task automatic checkDone(input int n, input logic got);
    if (got !== 1'b1)
      failRun($sformatf("request %0d got no done one cycle after it was issued", n));
  endtask

  // Lines that do not hold six hex fields are comments
  task automatic loadRequests;
    int                             fd;
    string                          line;
    logic [heapPkg::actionBits-1:0] a;
    logic [heapPkg::arrayBits-1:0]  r;
    logic [heapPkg::indexBits-1:0]  i;
    logic [heapPkg::dataBits-1:0]   o;
    logic [heapPkg::dataBits-1:0]   expResult;
    logic [heapPkg::errorBits-1:0]  expError;
    fd = $fopen("dv/heapInput.txt", "r");
    if (fd == 0) begin
      failRun("could not open the stimulus file dv/heapInput.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%h %h %h %h %h %h", a, r, i, o, expResult, expError) == 6) begin
          actionQ.push_back(a);
          arrayQ.push_back(r);
          indexQ.push_back(i);
          operandQ.push_back(o);
          resultQ.push_back(expResult);
          errorQ.push_back(expError);
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------------------------------------
  // Timeout and main sequence
  // --------------------------------------------------
  always @(posedge clock) begin
    cycleCount = cycleCount + 1;
    if (cycleLimit != 0 && cycleCount > cycleLimit)
      failRun($sformatf("timeout, no end of test after %0d cycles", cycleCount));
  end

  initial begin
    clock      = 1'b0;
    resetN     = 1'b0;                              // Reset held from time zero
    request    = 1'b0;
    action     = '0;
    array      = '0;
    index      = '0;
    operand    = '0;
    cycleCount = 0;
    cycleLimit = 0;
    loadRequests();
    if (actionQ.size() == 0) begin
      failRun("no requests found in dv/heapInput.txt");
    end else begin
      cycleLimit = actionQ.size() * 3 + 20;
      repeat (5) @(posedge clock);
      @(negedge clock);
      resetN = 1'b1;
      for (int n = 0; n < actionQ.size(); n++) begin
        request = 1'b1;                             // Driven on falling edge
        action  = actionQ[n];
        array   = arrayQ[n];
        index   = indexQ[n];
        operand = operandQ[n];
        @(negedge clock);                           // Answer settled half a cycle ago
        checkDone(n, done);
        checkResult(n, result, resultQ[n]);
        checkError(n, error, errorQ[n]);
      end
      request = 1'b0;
      @(negedge clock);                             // Strobe falls with no request
      if (done !== 1'b0)
        failRun("done stayed high one cycle after the last request");
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- src.f
logic/heapPkg.sv
logic/heapAllocator.sv
logic/accessControl.sv
logic/elementStore.sv
logic/arrayHeap.sv
dv/arrayHeapTb.sv

//--- dv/heapInput.txt
# action array index operand result error, all hex, codes as in heapPkg
03 0 0 0000 0000 1  # read before any alloc
07 0 0 0000 0000 0  # allocs in order
07 0 0 0000 0001 0
07 0 0 0000 0002 0
07 0 0 0000 0003 0
07 0 0 0000 0000 5  # no array left
08 2 0 0000 0000 0
08 1 0 0000 0000 0
07 0 0 0000 0001 0  # last freed comes back first
07 0 0 0000 0002 0
02 0 5 1234 1234 0  # write extends size to 6
04 0 0 0000 0006 0
02 0 3 00ff 00ff 0
03 0 3 0000 00ff 0
03 0 6 0000 0000 2  # beyond size
05 1 0 0011 0000 0  # eight pushes
05 1 0 0022 0000 0
05 1 0 0033 0000 0
05 1 0 0044 0000 0
05 1 0 0055 0000 0
05 1 0 0066 0000 0
05 1 0 0077 0000 0
05 1 0 0088 0000 0
05 1 0 0099 0000 3  # array full
06 1 0 0000 0088 0  # pops in reverse
06 1 0 0000 0077 0
06 1 0 0000 0066 0
06 2 0 0000 0000 4  # empty array
09 0 3 0001 0100 0  # add
0a 0 3 0100 0100 0  # addAfter gives old value
03 0 3 0000 0200 0
0b 0 3 0201 ffff 0  # subtract wraps
0c 0 3 ffff ffff 0  # subAfter gives old value
0f 0 3 00f0 00f0 0
10 0 3 0ff0 0f00 0
0d 0 3 0004 f000 0
0e 0 3 0008 00f0 0
11 0 3 0030 0030 0
12 0 3 0000 ffcf 0
08 3 0 0000 0000 0
02 3 0 5555 0000 1  # write to freed array
08 3 0 0000 0000 1  # double free
01 0 0 0000 0000 0  # clear heap
04 0 0 0000 0000 1
07 0 0 0000 0000 0  # numbering restarts
